// ==== zynq_pl.f ====
zynq_csr_pkg.sv
zynq_addr_pkg.sv
zynq_dram_req_if.sv
zynq_csr_regs.sv
zynq_addr_xlate.sv
zynq_status_regs.sv
zynq_pl_top.sv
zynq_pl_checker.sv
tb_zynq_pl_top.sv

// ==== Bender.yml ====
package:
  name: zynq_pl

sources:
  - files:
      - zynq_csr_pkg.sv
      - zynq_addr_pkg.sv
      - zynq_dram_req_if.sv
      - zynq_csr_regs.sv
      - zynq_addr_xlate.sv
      - zynq_status_regs.sv
      - zynq_pl_top.sv
  - target: test
    files:
      - zynq_pl_checker.sv
      - tb_zynq_pl_top.sv

// ==== tb_zynq_pl_top.sv ====
module tb_zynq_pl_top;

   import zynq_csr_pkg::*;
   import zynq_addr_pkg::*;

   localparam int clk_period  = 8;
   localparam int drive_delay = 1;
   localparam int num_host    = 48;
   localparam int num_dram    = 48;
   localparam int num_count   = 20;
   localparam int num_tag     = 16;

   // one cycle per item in each phase, doubled, plus room for writes and idles
   localparam int max_cycles  = 2 * (num_host + num_dram + 2 * num_count + num_tag) + 100;

   logic        aclk;
   logic        arst_n_i;
   logic        csr_w_v_i;
   logic [2:0]  csr_w_addr_i;
   logic [31:0] csr_w_data_i;
   logic [2:0]  csr_r_addr_i;
   logic [31:0] csr_r_data_o;
   logic        sys_reset_n_o;
   logic        tag_ck_o;
   logic        tag_data_o;
   logic        host_v_i;
   logic [31:0] host_addr_i;
   logic        bp_v_o;
   logic [31:0] bp_addr_o;
   logic        dram_wr_v_i;
   logic [31:0] dram_wr_addr_i;
   logic        dram_rd_v_i;
   logic [31:0] dram_rd_addr_i;
   logic        mem_wr_v_o;
   logic [31:0] mem_wr_addr_o;
   logic        mem_rd_v_o;
   logic [31:0] mem_rd_addr_o;

   int          checks;
   int          errors;
   logic        timed_out;
   integer      seed;

   zynq_pl_top zynq_pl_top_inst (
      .aclk             (aclk)
      , .arst_n_i       (arst_n_i)
      , .csr_w_v_i      (csr_w_v_i)
      , .csr_w_addr_i   (csr_w_addr_i)
      , .csr_w_data_i   (csr_w_data_i)
      , .csr_r_addr_i   (csr_r_addr_i)
      , .csr_r_data_o   (csr_r_data_o)
      , .sys_reset_n_o  (sys_reset_n_o)
      , .tag_ck_o       (tag_ck_o)
      , .tag_data_o     (tag_data_o)
      , .host_v_i       (host_v_i)
      , .host_addr_i    (host_addr_i)
      , .bp_v_o         (bp_v_o)
      , .bp_addr_o      (bp_addr_o)
      , .dram_wr_v_i    (dram_wr_v_i)
      , .dram_wr_addr_i (dram_wr_addr_i)
      , .dram_rd_v_i    (dram_rd_v_i)
      , .dram_rd_addr_i (dram_rd_addr_i)
      , .mem_wr_v_o     (mem_wr_v_o)
      , .mem_wr_addr_o  (mem_wr_addr_o)
      , .mem_rd_v_o     (mem_rd_v_o)
      , .mem_rd_addr_o  (mem_rd_addr_o)
   );

   zynq_pl_checker #(
      .max_cycles (max_cycles)
   ) checker_inst (
      .aclk             (aclk)
      , .arst_n_i       (arst_n_i)
      , .csr_w_v_i      (csr_w_v_i)
      , .csr_w_addr_i   (csr_w_addr_i)
      , .csr_w_data_i   (csr_w_data_i)
      , .csr_r_addr_i   (csr_r_addr_i)
      , .csr_r_data_i   (csr_r_data_o)
      , .sys_reset_n_i  (sys_reset_n_o)
      , .tag_ck_i       (tag_ck_o)
      , .tag_data_i     (tag_data_o)
      , .host_v_i       (host_v_i)
      , .host_addr_i    (host_addr_i)
      , .bp_v_i         (bp_v_o)
      , .bp_addr_i      (bp_addr_o)
      , .dram_wr_v_i    (dram_wr_v_i)
      , .dram_wr_addr_i (dram_wr_addr_i)
      , .dram_rd_v_i    (dram_rd_v_i)
      , .dram_rd_addr_i (dram_rd_addr_i)
      , .mem_wr_v_i     (mem_wr_v_o)
      , .mem_wr_addr_i  (mem_wr_addr_o)
      , .mem_rd_v_i     (mem_rd_v_o)
      , .mem_rd_addr_i  (mem_rd_addr_o)
      , .checks_o       (checks)
      , .errors_o       (errors)
      , .timed_out_o    (timed_out)
   );

   initial begin
      aclk = 1'b0;
      forever begin
         #(clk_period / 2) aclk = ~aclk;
      end
   end

   ////////////////////////////////////////
   // stimulus helpers

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   // strobes drop back and the cycle low word is read unless a phase says otherwise
   task automatic next_cycle();
      @(posedge aclk);
      #drive_delay;
      csr_w_v_i    = 1'b0;
      host_v_i     = 1'b0;
      dram_wr_v_i  = 1'b0;
      dram_rd_v_i  = 1'b0;
      csr_r_addr_i = csr_stat_cycle;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         next_cycle();
      end
   endtask

   task automatic write_csr(input logic [2:0] addr, input logic [31:0] data);
      next_cycle();
      csr_w_v_i    = 1'b1;
      csr_w_addr_i = addr;
      csr_w_data_i = data;
   endtask

   task automatic host_burst(input int n);
      logic [31:0] addr;
      logic [31:0] sel;
      for (int i = 0; i < n; i++) begin
         next_cycle();
         addr = rand_word();
         sel  = rand_word();
         // both sides of the split, the boundary itself first
         if (i == 0) begin
            addr = host_window_split - 1;
         end else if (i == 1) begin
            addr = host_window_split;
         end else if (i % 2 == 0) begin
            addr = addr & 32'h1fff_ffff;
         end else if (addr < host_window_split) begin
            addr = addr | host_window_split;
         end
         host_v_i     = (i < 2) || (sel[1:0] != 2'b00);
         host_addr_i  = addr;
         csr_r_addr_i = sel[6:4];
      end
   endtask

   task automatic dram_burst(input int n);
      logic [31:0] wr;
      logic [31:0] rd;
      logic [31:0] sel;
      for (int i = 0; i < n; i++) begin
         next_cycle();
         wr  = rand_word();
         rd  = rand_word();
         sel = rand_word();
         // core DRAM sits in the 1 GB window at 0x8000_0000
         dram_wr_v_i    = sel[0];
         dram_wr_addr_i = {2'b10, wr[29:0]};
         dram_rd_v_i    = sel[1];
         dram_rd_addr_i = {2'b10, rd[29:0]};
         csr_r_addr_i   = sel[6:4];
      end
   endtask

   task automatic read_all_stat();
      for (int i = 0; i < 8; i++) begin
         next_cycle();
         csr_r_addr_i = i[2:0];
      end
   endtask

   task automatic bitbang_burst(input int n);
      logic [31:0] bits;
      for (int i = 0; i < n; i++) begin
         bits = rand_word();
         write_csr(csr_ctrl_bitbang, {31'd0, bits[0]});
      end
   endtask

   ////////////////////////////////////////
   // test sequence

   initial begin
      seed           = 32'h648387eb;
      arst_n_i       = 1'b0;
      csr_w_v_i      = 1'b0;
      csr_w_addr_i   = '0;
      csr_w_data_i   = '0;
      csr_r_addr_i   = '0;
      host_v_i       = 1'b0;
      host_addr_i    = '0;
      dram_wr_v_i    = 1'b0;
      dram_wr_addr_i = '0;
      dram_rd_v_i    = 1'b0;
      dram_rd_addr_i = '0;
      repeat (2) @(posedge aclk);
      #drive_delay;
      arst_n_i = 1'b1;

      // system still held, counter must stay at zero
      idle_cycles(3);
      write_csr(csr_ctrl_sys_reset, 32'h1);
      host_burst(num_host);
      write_csr(csr_ctrl_dram_base, rand_word() & 32'hfff0_0000);
      dram_burst(num_dram);
      idle_cycles(4);
      read_all_stat();

      // counter runs, then is held at zero, then runs again
      idle_cycles(num_count);
      write_csr(csr_ctrl_sys_reset, 32'h0);
      idle_cycles(num_count);
      write_csr(csr_ctrl_sys_reset, 32'h1);
      bitbang_burst(num_tag);
      idle_cycles(4);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      wait (timed_out === 1'b1);
      $display("timeout, the run did not finish within %0d cycles", max_cycles);
      $display("checks %0d, errors %0d", checks, errors);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== zynq_pl_checker.sv ====
module zynq_pl_checker #(
   parameter int max_cycles = 1000
) (
   input  logic                                      aclk
   , input  logic                                    arst_n_i

   // host register port
   , input  logic                                    csr_w_v_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_w_addr_i
   , input  logic [zynq_csr_pkg::csr_data_width-1:0] csr_w_data_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_r_addr_i
   , input  logic [zynq_csr_pkg::csr_data_width-1:0] csr_r_data_i

   // system control
   , input  logic                                    sys_reset_n_i
   , input  logic                                    tag_ck_i
   , input  logic                                    tag_data_i

   // host window
   , input  logic                                    host_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    host_addr_i
   , input  logic                                    bp_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    bp_addr_i

   // DRAM requests on both sides
   , input  logic                                    dram_wr_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    dram_wr_addr_i
   , input  logic                                    dram_rd_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    dram_rd_addr_i
   , input  logic                                    mem_wr_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    mem_wr_addr_i
   , input  logic                                    mem_rd_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    mem_rd_addr_i

   // run state for the testbench top
   , output int                                      checks_o
   , output int                                      errors_o
   , output logic                                    timed_out_o
);

   import zynq_csr_pkg::*;
   import zynq_addr_pkg::*;

   int checks = 0;
   int errors = 0;
   int cycles = 0;
   logic expired = 1'b0;

   // expectations for the outputs after the next edge
   logic                        exp_bp_v;
   logic [31:0]                 exp_bp_addr;
   logic                        exp_wr_v;
   logic [31:0]                 exp_wr_addr;
   logic                        exp_rd_v;
   logic [31:0]                 exp_rd_addr;
   logic                        exp_r_v;
   logic [31:0]                 exp_r_data;

   // shadow state of the shell
   logic                        sys_model;
   logic                        prev_sys;
   logic                        tag_ck_model;
   logic                        tag_data_model;
   logic [31:0]                 base_model;
   logic [63:0]                 cnt_model;
   logic [profiler_regions-1:0] shadow_mask;
   logic [profiler_regions-1:0] set_d0;
   logic [profiler_regions-1:0] set_d1;

   assign checks_o    = checks;
   assign errors_o    = errors;
   assign timed_out_o = expired;

   ////////////////////////////////////////
   // reference model

   // low window goes to core DRAM, the rest keeps its low 28 bits
   function automatic logic [31:0] host_xlate(input logic [31:0] addr);
      if (addr < 32'h2000_0000) begin
         return addr + 32'h8000_0000;
      end
      return {4'h0, addr[27:0]};
   endfunction

   function automatic logic [31:0] dram_xlate(input logic [31:0] addr, input logic [31:0] base);
      return {~addr[31], addr[30:0]} + base;
   endfunction

   // 2 spare bits, then 7 region bits above a 23-bit offset
   function automatic logic [6:0] region_of(input logic [31:0] addr);
      return addr[29:23];
   endfunction

   function automatic logic [31:0] stat_word(input logic [2:0] idx);
      if (idx < 4) begin
         return shadow_mask[idx*32 +: 32];
      end else if (idx == 4) begin
         return cnt_model[31:0];
      end else if (idx == 5) begin
         return cnt_model[63:32];
      end
      return '0;
   endfunction

   task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // comparison, half a cycle away from the edges

   always @(negedge aclk) begin
      if (arst_n_i !== 1'b1) begin
         exp_bp_v       = 1'b0;
         exp_wr_v       = 1'b0;
         exp_rd_v       = 1'b0;
         exp_r_v        = 1'b0;
         sys_model      = 1'b0;
         prev_sys       = 1'b0;
         tag_ck_model   = 1'b0;
         tag_data_model = 1'b0;
         base_model     = '0;
         cnt_model      = '0;
         shadow_mask    = '0;
         set_d0         = '0;
         set_d1         = '0;
      end else begin
         compare_word("bp_v_o", bp_v_i, exp_bp_v);
         if (exp_bp_v) begin
            compare_word("bp_addr_o", bp_addr_i, exp_bp_addr);
         end
         compare_word("mem_wr_v_o", mem_wr_v_i, exp_wr_v);
         if (exp_wr_v) begin
            compare_word("mem_wr_addr_o", mem_wr_addr_i, exp_wr_addr);
         end
         compare_word("mem_rd_v_o", mem_rd_v_i, exp_rd_v);
         if (exp_rd_v) begin
            compare_word("mem_rd_addr_o", mem_rd_addr_i, exp_rd_addr);
         end
         if (exp_r_v) begin
            compare_word("csr_r_data_o", csr_r_data_i, exp_r_data);
         end
         compare_word("sys_reset_n_o", sys_reset_n_i, sys_model);
         compare_word("tag_ck_o", tag_ck_i, tag_ck_model);
         compare_word("tag_data_o", tag_data_i, tag_data_model);

         // advance the shadow state by one edge
         cnt_model    = prev_sys ? cnt_model + 1 : '0;
         prev_sys     = sys_model;
         // a request reaches the mask two edges after it is captured
         shadow_mask |= set_d1;
         set_d1       = set_d0;
         set_d0       = '0;
         if (dram_wr_v_i) begin
            set_d0[region_of(dram_wr_addr_i)] = 1'b1;
         end
         if (dram_rd_v_i) begin
            set_d0[region_of(dram_rd_addr_i)] = 1'b1;
         end

         exp_bp_v    = host_v_i;
         exp_bp_addr = host_xlate(host_addr_i);
         exp_wr_v    = dram_wr_v_i;
         exp_wr_addr = dram_xlate(dram_wr_addr_i, base_model);
         exp_rd_v    = dram_rd_v_i;
         exp_rd_addr = dram_xlate(dram_rd_addr_i, base_model);
         exp_r_v     = 1'b1;
         exp_r_data  = stat_word(csr_r_addr_i);

         // control writes take effect after the next edge
         if (csr_w_v_i) begin
            case (csr_w_addr_i)
               3'd0: sys_model = csr_w_data_i[0];
               3'd1: begin
                  tag_data_model = csr_w_data_i[0];
                  tag_ck_model   = ~tag_ck_model;
               end
               3'd2: base_model = csr_w_data_i;
               default: begin
               end
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // timeout

   always @(posedge aclk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         expired = 1'b1;
      end
   end

endmodule

// ==== zynq_pl_top.sv ====
module zynq_pl_top (
   input  logic                                      aclk
   , input  logic                                    arst_n_i

   // host register port
   , input  logic                                    csr_w_v_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_w_addr_i
   , input  logic [zynq_csr_pkg::csr_data_width-1:0] csr_w_data_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_r_addr_i
   , output logic [zynq_csr_pkg::csr_data_width-1:0] csr_r_data_o

   // system control
   , output logic                                    sys_reset_n_o
   , output logic                                    tag_ck_o
   , output logic                                    tag_data_o

   // host window
   , input  logic                                    host_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    host_addr_i
   , output logic                                    bp_v_o
   , output logic [zynq_addr_pkg::addr_width-1:0]    bp_addr_o

   // core DRAM requests in, host DRAM requests out
   , input  logic                                    dram_wr_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    dram_wr_addr_i
   , input  logic                                    dram_rd_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]    dram_rd_addr_i
   , output logic                                    mem_wr_v_o
   , output logic [zynq_addr_pkg::addr_width-1:0]    mem_wr_addr_o
   , output logic                                    mem_rd_v_o
   , output logic [zynq_addr_pkg::addr_width-1:0]    mem_rd_addr_o
);

   import zynq_addr_pkg::*;

   logic [addr_width-1:0] dram_base;

   zynq_dram_req_if dram_req ();

   ////////////////////////////////////////
   // control registers

   zynq_csr_regs csr_regs_inst (
      .aclk            (aclk)
      , .arst_n_i      (arst_n_i)
      , .csr_w_v_i     (csr_w_v_i)
      , .csr_w_addr_i  (csr_w_addr_i)
      , .csr_w_data_i  (csr_w_data_i)
      , .sys_reset_n_o (sys_reset_n_o)
      , .dram_base_o   (dram_base)
      , .tag_ck_o      (tag_ck_o)
      , .tag_data_o    (tag_data_o)
   );

   ////////////////////////////////////////
   // address translation

   zynq_addr_xlate addr_xlate_inst (
      .aclk             (aclk)
      , .arst_n_i       (arst_n_i)
      , .host_v_i       (host_v_i)
      , .host_addr_i    (host_addr_i)
      , .dram_base_i    (dram_base)
      , .dram_wr_v_i    (dram_wr_v_i)
      , .dram_wr_addr_i (dram_wr_addr_i)
      , .dram_rd_v_i    (dram_rd_v_i)
      , .dram_rd_addr_i (dram_rd_addr_i)
      , .bp_v_o         (bp_v_o)
      , .bp_addr_o      (bp_addr_o)
      , .mem_wr_v_o     (mem_wr_v_o)
      , .mem_wr_addr_o  (mem_wr_addr_o)
      , .mem_rd_v_o     (mem_rd_v_o)
      , .mem_rd_addr_o  (mem_rd_addr_o)
      , .dram_req       (dram_req.xlate)
   );

   ////////////////////////////////////////
   // profiler, counter and readback

   zynq_status_regs status_regs_inst (
      .aclk            (aclk)
      , .arst_n_i      (arst_n_i)
      , .sys_reset_n_i (sys_reset_n_o)
      , .dram_req      (dram_req.profiler)
      , .csr_r_addr_i  (csr_r_addr_i)
      , .csr_r_data_o  (csr_r_data_o)
   );

endmodule

// ==== zynq_status_regs.sv ====
module zynq_status_regs (
   input  logic                                      aclk
   , input  logic                                    arst_n_i
   , input  logic                                    sys_reset_n_i

   // core DRAM requests to profile
   , zynq_dram_req_if.profiler                       dram_req

   // host read port
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_r_addr_i
   , output logic [zynq_csr_pkg::csr_data_width-1:0] csr_r_data_o
);

   import zynq_csr_pkg::*;
   import zynq_addr_pkg::*;

   logic [profiler_regions-1:0]                  mask_r;
   logic [profiler_regions-1:0]                  mask_set;
   logic [2*csr_data_width-1:0]                  cycle_r;
   logic [num_stat_regs-1:0][csr_data_width-1:0] stat_words;
   logic [csr_data_width-1:0]                    r_data_r;

   ////////////////////////////////////////
   // memory profiler

   // a write and a read may hit two regions in the same cycle
   always_comb begin
      mask_set = '0;
      if (dram_req.wr_v) begin
         mask_set[dram_req.wr_addr.fields.region] = 1'b1;
      end
      if (dram_req.rd_v) begin
         mask_set[dram_req.rd_addr.fields.region] = 1'b1;
      end
   end

   always_ff @(posedge aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mask_r <= '0;
      end else begin
         mask_r <= mask_r | mask_set;
      end
   end

   ////////////////////////////////////////
   // cycle counter

   // counts only while the system runs
   always_ff @(posedge aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cycle_r <= '0;
      end else if (!sys_reset_n_i) begin
         cycle_r <= '0;
      end else begin
         cycle_r <= cycle_r + 1'b1;
      end
   end

   ////////////////////////////////////////
   // readback

   always_comb begin
      stat_words[csr_stat_profiler +: profiler_regions/csr_data_width] = mask_r;
      stat_words[csr_stat_cycle +: 2] = cycle_r;
   end

   always_ff @(posedge aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_data_r <= '0;
      end else if (csr_r_addr_i < num_stat_regs) begin
         r_data_r <= stat_words[csr_r_addr_i];
      end else begin
         // holes in the map read as zero
         r_data_r <= '0;
      end
   end

   assign csr_r_data_o = r_data_r;

   ////////////////////////////////////////
   // checks

   // profiler bits are sticky, only the async reset clears them
   mask_sticky_a: assert property (
      @(posedge aclk) disable iff (!arst_n_i)
      (mask_r & $past(mask_r)) == $past(mask_r)
   ) else $error("profiler mask lost a bit");

endmodule

// ==== zynq_addr_xlate.sv ====
module zynq_addr_xlate (
   input  logic                                    aclk
   , input  logic                                  arst_n_i

   // host window into the core
   , input  logic                                  host_v_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]  host_addr_i
   , input  logic [zynq_addr_pkg::addr_width-1:0]  dram_base_i

   // core DRAM requests
   , input  logic                                  dram_wr_v_i
   , input  zynq_addr_pkg::bp_dram_addr_u          dram_wr_addr_i
   , input  logic                                  dram_rd_v_i
   , input  zynq_addr_pkg::bp_dram_addr_u          dram_rd_addr_i

   // translated host access, core address map
   , output logic                                  bp_v_o
   , output logic [zynq_addr_pkg::addr_width-1:0]  bp_addr_o

   // translated DRAM requests, host DRAM region
   , output logic                                  mem_wr_v_o
   , output logic [zynq_addr_pkg::addr_width-1:0]  mem_wr_addr_o
   , output logic                                  mem_rd_v_o
   , output logic [zynq_addr_pkg::addr_width-1:0]  mem_rd_addr_o

   // core-side copy for the profiler
   , zynq_dram_req_if.xlate                        dram_req
);

   import zynq_addr_pkg::*;

   // host window 0x0000_0000..0x1fff_ffff maps to core DRAM,
   // 0x2000_0000 and up folds down onto the core's local space
   function automatic logic [addr_width-1:0] host_xlate(input logic [addr_width-1:0] addr);
      logic [addr_width-1:0] res;
      if (addr < host_window_split) begin
         res = addr + bp_dram_offset;
      end else begin
         res = {{(addr_width-host_local_mask_width){1'b0}},
                addr[host_local_mask_width-1:0]};
      end
      return res;
   endfunction

   // strip the core DRAM base with an xor, then move into the host region
   function automatic logic [addr_width-1:0] dram_xlate(
      input bp_dram_addr_u         addr,
      input logic [addr_width-1:0] base
   );
      return (addr.word ^ bp_dram_offset) + base;
   endfunction

   logic                  bp_v_r;
   logic [addr_width-1:0] bp_addr_r;
   logic                  wr_v_r;
   logic                  rd_v_r;
   logic [addr_width-1:0] mem_wr_addr_r;
   logic [addr_width-1:0] mem_rd_addr_r;
   bp_dram_addr_u         core_wr_addr_r;
   bp_dram_addr_u         core_rd_addr_r;

   ////////////////////////////////////////
   // request valids

   always_ff @(posedge aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bp_v_r <= 1'b0;
         wr_v_r <= 1'b0;
         rd_v_r <= 1'b0;
      end else begin
         bp_v_r <= host_v_i;
         wr_v_r <= dram_wr_v_i;
         rd_v_r <= dram_rd_v_i;
      end
   end

   ////////////////////////////////////////
   // translated addresses

   always_ff @(posedge aclk) begin
      if (host_v_i) begin
         bp_addr_r <= host_xlate(host_addr_i);
      end
      if (dram_wr_v_i) begin
         mem_wr_addr_r  <= dram_xlate(dram_wr_addr_i, dram_base_i);
         core_wr_addr_r <= dram_wr_addr_i;
      end
      if (dram_rd_v_i) begin
         mem_rd_addr_r  <= dram_xlate(dram_rd_addr_i, dram_base_i);
         core_rd_addr_r <= dram_rd_addr_i;
      end
   end

   assign bp_v_o        = bp_v_r;
   assign bp_addr_o     = bp_addr_r;
   assign mem_wr_v_o    = wr_v_r;
   assign mem_wr_addr_o = mem_wr_addr_r;
   assign mem_rd_v_o    = rd_v_r;
   assign mem_rd_addr_o = mem_rd_addr_r;

   // profiler sees the untranslated address in the same cycle
   assign dram_req.wr_v    = wr_v_r;
   assign dram_req.wr_addr = core_wr_addr_r;
   assign dram_req.rd_v    = rd_v_r;
   assign dram_req.rd_addr = core_rd_addr_r;

   ////////////////////////////////////////
   // checks

   bp_v_a: assert property (
      @(posedge aclk) disable iff (!arst_n_i)
      bp_v_o |-> $past(host_v_i)
   ) else $error("host window output without a request");

   mem_v_a: assert property (
      @(posedge aclk) disable iff (!arst_n_i)
      (mem_wr_v_o |-> $past(dram_wr_v_i)) and (mem_rd_v_o |-> $past(dram_rd_v_i))
   ) else $error("DRAM output without a core request");

endmodule

// ==== zynq_csr_regs.sv ====
module zynq_csr_regs (
   input  logic                                   aclk
   , input  logic                                 arst_n_i

   // host write strobe
   , input  logic                                 csr_w_v_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_w_addr_i
   , input  logic [zynq_csr_pkg::csr_data_width-1:0] csr_w_data_i

   // control outputs
   , output logic                                 sys_reset_n_o
   , output logic [zynq_addr_pkg::addr_width-1:0] dram_base_o
   , output logic                                 tag_ck_o
   , output logic                                 tag_data_o
);

   import zynq_csr_pkg::*;
   import zynq_addr_pkg::*;

   logic                  sys_reset_n_r;
   logic [addr_width-1:0] dram_base_r;
   logic                  tag_ck_r;
   logic                  tag_data_r;

   ////////////////////////////////////////
   // write decode

   always_ff @(posedge aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         // system comes up held in reset until the host releases it
         sys_reset_n_r <= 1'b0;
         dram_base_r   <= '0;
         tag_ck_r      <= 1'b0;
         tag_data_r    <= 1'b0;
      end else if (csr_w_v_i) begin
         case (csr_w_addr_i)
            csr_ctrl_sys_reset: begin
               sys_reset_n_r <= csr_w_data_i[0];
            end
            csr_ctrl_bitbang: begin
               // data and clock move together, the tag master samples
               // on either edge of tag_ck
               tag_data_r <= csr_w_data_i[0];
               tag_ck_r   <= ~tag_ck_r;
            end
            csr_ctrl_dram_base: begin
               dram_base_r <= csr_w_data_i[addr_width-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   assign sys_reset_n_o = sys_reset_n_r;
   assign dram_base_o   = dram_base_r;
   assign tag_ck_o      = tag_ck_r;
   assign tag_data_o    = tag_data_r;

   ////////////////////////////////////////
   // checks

   // host software only knows the three control registers
   ctrl_idx_a: assert property (
      @(posedge aclk) disable iff (!arst_n_i)
      csr_w_v_i |-> (csr_w_addr_i < num_ctrl_regs)
   ) else $error("write to control index %0d outside the map", csr_w_addr_i);

endmodule

// ==== zynq_dram_req_if.sv ====
// registered core-side DRAM requests, one write and one read channel
interface zynq_dram_req_if;

   import zynq_addr_pkg::*;

   // write channel
   logic          wr_v;
   bp_dram_addr_u wr_addr;

   // read channel
   logic          rd_v;
   bp_dram_addr_u rd_addr;

   // address translator, drives the requests
   modport xlate (
      output wr_v
      , output wr_addr
      , output rd_v
      , output rd_addr
   );

   // memory profiler, observes them
   modport profiler (
      input wr_v
      , input wr_addr
      , input rd_v
      , input rd_addr
   );

endinterface

// ==== zynq_addr_pkg.sv ====
package zynq_addr_pkg;

   // every address in the shell is this wide
   localparam int addr_width = 32;

   ////////////////////////////////////////
   // host window

   // addresses below the split land in core DRAM, the rest in local space
   localparam logic [addr_width-1:0] host_window_split = 32'h2000_0000;

   // start of DRAM in the core's address map
   localparam logic [addr_width-1:0] bp_dram_offset = 32'h8000_0000;

   // offset bits kept for the local range (256 MB)
   localparam int host_local_mask_width = 28;

   ////////////////////////////////////////
   // memory profiler

   // one mask bit per 8 MB region of the 1 GB window
   localparam int profiler_regions = 128;
   localparam int region_width = 7;

   // field widths of a core DRAM address
   localparam int dram_offset_width = 23;
   localparam int dram_spare_width = addr_width - region_width - dram_offset_width;

   // core DRAM address split into its fields
   typedef struct packed {
      logic [dram_spare_width-1:0]  spare;
      logic [region_width-1:0]      region;
      logic [dram_offset_width-1:0] offset;
   } bp_dram_addr_s;

   // the translator needs the flat word, the profiler only the region
   typedef union packed {
      logic [addr_width-1:0] word;
      bp_dram_addr_s         fields;
   } bp_dram_addr_u;

endpackage

// ==== zynq_csr_pkg.sv ====
package zynq_csr_pkg;

   ////////////////////////////////////////
   // host register port

   // width of one host register word
   localparam int csr_data_width = 32;

   // width of a register index on the host port
   localparam int csr_addr_width = 3;

   ////////////////////////////////////////
   // control registers, written by the host

   // bit 0 is the active-low system reset
   localparam logic [csr_addr_width-1:0] csr_ctrl_sys_reset = 3'd0;

   // bit 0 is the next tag bit, every write sends one bit
   localparam logic [csr_addr_width-1:0] csr_ctrl_bitbang = 3'd1;

   // base of the host DRAM region given to the core
   localparam logic [csr_addr_width-1:0] csr_ctrl_dram_base = 3'd2;

   localparam int num_ctrl_regs = 3;

   ////////////////////////////////////////
   // status registers, read by the host

   // four words of the memory profiler mask, word 0 holds regions 0..31
   localparam logic [csr_addr_width-1:0] csr_stat_profiler = 3'd0;

   // free-running cycle counter, low word first
   localparam logic [csr_addr_width-1:0] csr_stat_cycle = 3'd4;

   localparam int num_stat_regs = 6;

endpackage
